// File: filelist.f
+incdir+source
source/mcu_pkg.sv
source/obi_bus_ctrl.sv
source/ram_bank_array.sv
source/ao_periph_regs.sv
source/rv_timer.sv
source/mini_mcu_top.sv
sim/tb_mini_mcu.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --timescale 1ns/1ps \
  --top-module tb_mini_mcu -f filelist.f -o tb_mini_mcu_sim

out=$(./obj_dir/tb_mini_mcu_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "^Test passed$"; then
  exit 0
fi
exit 1

// File: sim/tb_mini_mcu.sv
// Directed testbench for the always-on slice, acting as the OBI master.
// Inputs change 1 ns after a rising edge, outputs are sampled on the falling edge.
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cfg.svh"

module tb_mini_mcu
  import mcu_pkg::*;
();

  localparam int          GNT_TIMEOUT  = 20;
  localparam int          POLL_TIMEOUT = 20;
  localparam logic [31:0] RAM_BYTES    = 32'(`MCU_NUM_BANKS * `MCU_BANK_WORDS * 4);

  logic                   clk;
  logic                   arst_n;
  obi_req_t               obi_req;
  obi_rsp_t               obi_rsp;
  logic [`MCU_GPIO_W-1:0] gpio_in;
  logic [`MCU_GPIO_W-1:0] gpio_out;
  logic [`MCU_GPIO_W-1:0] gpio_oe;
  logic                   exit_valid;
  logic [31:0]            exit_value;
  logic [31:0]            irq;
  int                     errors;
  int                     tests_run;
  int                     tests_failed;

  mini_mcu_top u_dut (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .obi_req_i    (obi_req),
    .obi_rsp_o    (obi_rsp),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out),
    .gpio_oe_o    (gpio_oe),
    .exit_valid_o (exit_valid),
    .exit_value_o (exit_value),
    .irq_o        (irq)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // hang guard for the whole run
  initial begin
    repeat (20000) @(posedge clk);
    $display("simulation did not finish within the cycle limit");
    $display("Test failed");
    $finish;
  end

  // leaves the caller 1 ns after a rising edge
  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error %s expected %h got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int start_errors);
    tests_run++;
    if (errors == start_errors) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - start_errors);
    end
  endtask

  // one access, started 1 ns after a rising edge
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be, output logic [31:0] rdata,
                            output logic err);
    int   waited;
    logic granted;
    waited        = 0;
    granted       = 1'b0;
    rdata         = '0;
    err           = 1'b0;
    obi_req.req   = 1'b1;
    obi_req.we    = we;
    obi_req.be    = be;
    obi_req.addr  = addr;
    obi_req.wdata = wdata;
    while (!granted && waited < GNT_TIMEOUT) begin
      @(negedge clk);
      if (obi_rsp.gnt) granted = 1'b1;
      else waited++;
    end
    if (!granted) begin
      $display("no grant within %0d cycles for address %h", GNT_TIMEOUT, addr);
      errors++;
    end else begin
      if (obi_rsp.rvalid) begin
        $display("rvalid came in the grant cycle for address %h", addr);
        errors++;
      end
      // request stays up through the response cycle to probe the stall
      @(negedge clk);
      if (!obi_rsp.rvalid) begin
        $display("rvalid missing one cycle after the grant for address %h", addr);
        errors++;
      end
      if (obi_rsp.gnt) begin
        $display("grant given in the rvalid cycle for address %h", addr);
        errors++;
      end
      rdata = obi_rsp.rdata;
      err   = obi_rsp.err;
    end
    @(posedge clk);
    #1;
    obi_req = '0;
  endtask

  task automatic obi_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be, output logic err);
    logic [31:0] unused_rdata;
    bus_access(1'b1, addr, data, be, unused_rdata, err);
  endtask

  task automatic obi_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic err);
    bus_access(1'b0, addr, 32'h0, 4'hF, data, err);
  endtask

  function automatic logic [31:0] ao_addr(input ao_reg_e r);
    return `MCU_AO_BASE + 32'(r);
  endfunction

  task automatic ao_write(input ao_reg_e r, input logic [31:0] data);
    logic err;
    obi_write(ao_addr(r), data, 4'hF, err);
    expect_eq("err", 32'(err), 32'h0);
  endtask

  task automatic ao_read(input ao_reg_e r, output logic [31:0] data);
    logic err;
    obi_read(ao_addr(r), data, err);
    expect_eq("err", 32'(err), 32'h0);
  endtask

  task automatic reset_timing_test();
    logic [31:0] rdata;
    int          start;
    start = errors;
    expect_eq("gnt", 32'(obi_rsp.gnt), 32'h0);
    expect_eq("rvalid", 32'(obi_rsp.rvalid), 32'h0);
    expect_eq("err", 32'(obi_rsp.err), 32'h0);
    expect_eq("exit_valid_o", 32'(exit_valid), 32'h0);
    expect_eq("exit_value_o", exit_value, 32'h0);
    expect_eq("gpio_o", 32'(gpio_out), 32'h0);
    expect_eq("gpio_oe_o", 32'(gpio_oe), 32'h0);
    expect_eq("irq_o", irq, 32'h0);
    ao_read(AO_TIMER_CTRL, rdata);
    expect_eq("AO_TIMER_CTRL", rdata, 32'h0);
    ao_read(AO_TIMER_VALUE, rdata);
    expect_eq("AO_TIMER_VALUE", rdata, 32'h0);
    ao_read(AO_TIMER_PRESCALE, rdata);
    expect_eq("AO_TIMER_PRESCALE", rdata, 32'h0);
    ao_read(AO_TIMER_CMP, rdata);
    expect_eq("AO_TIMER_CMP", rdata, 32'h0);
    finish_test("reset_timing", start);
  endtask

  task automatic ram_test();
    logic [31:0] addrs [8];
    logic [31:0] model [8];
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [3:0]  be;
    logic        err;
    int          word;
    int          start;
    start = errors;
    // four distinct words per bank
    for (int i = 0; i < 8; i++) begin
      word     = (i % 4) * 64 + int'($urandom_range(0, 63));
      addrs[i] = `MCU_RAM_BASE + 32'(((i / 4) * `MCU_BANK_WORDS + word) * 4);
      model[i] = $urandom;
      obi_write(addrs[i], model[i], 4'hF, err);
      expect_eq("err", 32'(err), 32'h0);
    end
    for (int i = 0; i < 8; i += 2) begin
      be    = 4'($urandom_range(1, 14));
      wdata = $urandom;
      obi_write(addrs[i], wdata, be, err);
      expect_eq("err", 32'(err), 32'h0);
      for (int b = 0; b < 4; b++) begin
        if (be[b]) model[i][8*b +: 8] = wdata[8*b +: 8];
      end
    end
    for (int i = 0; i < 8; i++) begin
      obi_read(addrs[i], rdata, err);
      expect_eq("err", 32'(err), 32'h0);
      expect_eq("ram rdata", rdata, model[i]);
    end
    finish_test("ram", start);
  endtask

  task automatic unmapped_test();
    logic [31:0] keep_v;
    logic [31:0] before_v;
    logic [31:0] after_v;
    logic [31:0] rdata;
    logic        err;
    int          start;
    start = errors;
    obi_read(32'h1000_0000, rdata, err);
    expect_eq("err", 32'(err), 32'h1);
    expect_eq("rdata", rdata, 32'h0);
    // word 1 gets a known value first
    keep_v = $urandom;
    obi_write(`MCU_RAM_BASE + 32'h4, keep_v, 4'hF, err);
    expect_eq("err", 32'(err), 32'h0);
    obi_read(`MCU_RAM_BASE + 32'h4, before_v, err);
    expect_eq("err", 32'(err), 32'h0);
    expect_eq("ram rdata", before_v, keep_v);
    // just past the RAM window, same low bits as word 1
    bus_access(1'b1, `MCU_RAM_BASE + RAM_BYTES + 32'h4, ~keep_v, 4'hF, rdata, err);
    expect_eq("err", 32'(err), 32'h1);
    expect_eq("rdata", rdata, 32'h0);
    obi_read(`MCU_RAM_BASE + 32'h4, after_v, err);
    expect_eq("err", 32'(err), 32'h0);
    expect_eq("ram rdata", after_v, keep_v);
    finish_test("unmapped", start);
  endtask

  task automatic exit_gpio_test();
    logic [31:0]            value;
    logic [31:0]            rdata;
    logic [`MCU_GPIO_W-1:0] pattern;
    logic                   matched;
    int                     polls;
    int                     start;
    start = errors;
    value = $urandom;
    ao_write(AO_EXIT_VALUE, value);
    expect_eq("exit_value_o", exit_value, value);
    expect_eq("exit_valid_o", 32'(exit_valid), 32'h0);
    ao_write(AO_EXIT_VALID, 32'h1);
    expect_eq("exit_valid_o", 32'(exit_valid), 32'h1);
    pattern = `MCU_GPIO_W'($urandom);
    ao_write(AO_GPIO_OUT, 32'(pattern));
    expect_eq("gpio_o", 32'(gpio_out), 32'(pattern));
    pattern = `MCU_GPIO_W'($urandom);
    ao_write(AO_GPIO_OE, 32'(pattern));
    expect_eq("gpio_oe_o", 32'(gpio_oe), 32'(pattern));
    pattern = `MCU_GPIO_W'($urandom_range(1, 255));
    gpio_in = pattern;
    matched = 1'b0;
    polls   = 0;
    rdata   = '0;
    while (!matched && polls < POLL_TIMEOUT) begin
      ao_read(AO_GPIO_IN, rdata);
      if (rdata == 32'(pattern)) matched = 1'b1;
      else polls++;
    end
    if (!matched) begin
      $display("AO_GPIO_IN never showed %h, last read %h", pattern, rdata);
      errors++;
    end
    finish_test("exit_gpio", start);
  endtask

  task automatic timer_test();
    logic [31:0] mtime;
    logic        fired;
    int          presc;
    int          cmp;
    int          limit;
    int          waited;
    int          start;
    start = errors;
    presc = $urandom_range(1, 4);
    cmp   = $urandom_range(5, 20);
    limit = (cmp + 1) * (presc + 1) + 20;
    ao_write(AO_TIMER_PRESCALE, 32'(presc));
    ao_write(AO_TIMER_VALUE, 32'h0);
    ao_write(AO_TIMER_CMP, 32'(cmp));
    ao_write(AO_TIMER_CTRL, 32'h1);
    fired  = 1'b0;
    waited = 0;
    while (!fired && waited < limit) begin
      @(negedge clk);
      if (irq[`MCU_IRQ_TIMER_BIT]) fired = 1'b1;
      else waited++;
    end
    idle_cycles(1);
    if (!fired) begin
      $display("timer interrupt did not rise within %0d cycles", limit);
      errors++;
    end else if (waited + 4 < cmp * (presc + 1)) begin
      $display("timer interrupt rose after only %0d cycles", waited);
      errors++;
    end
    expect_eq("irq_o", irq, 32'(1) << `MCU_IRQ_TIMER_BIT);
    ao_read(AO_TIMER_VALUE, mtime);
    if (mtime < 32'(cmp)) begin
      $display("error AO_TIMER_VALUE expected at least %h got %h", cmp, mtime);
      errors++;
    end
    ao_write(AO_TIMER_CMP, mtime + 32'd1000);
    expect_eq("irq_o", irq, 32'h0);
    ao_write(AO_TIMER_CMP, 32'(cmp));
    expect_eq("irq_o", irq, 32'(1) << `MCU_IRQ_TIMER_BIT);
    ao_write(AO_TIMER_CTRL, 32'h0);
    expect_eq("irq_o", irq, 32'h0);
    finish_test("timer", start);
  endtask

  task automatic gpio_irq_test();
    logic [31:0] rdata;
    logic        fired;
    int          bit_on;
    int          bit_off;
    int          waited;
    int          start;
    start   = errors;
    gpio_in = '0;
    idle_cycles(5);
    bit_on  = $urandom_range(0, `MCU_GPIO_W - 1);
    bit_off = (bit_on + 1) % `MCU_GPIO_W;
    ao_write(AO_GPIO_INTR_EN, 32'(1) << bit_on);
    gpio_in[bit_on] = 1'b1;
    fired  = 1'b0;
    waited = 0;
    while (!fired && waited < POLL_TIMEOUT) begin
      @(negedge clk);
      if (irq[`MCU_IRQ_GPIO_BASE + bit_on]) fired = 1'b1;
      else waited++;
    end
    idle_cycles(1);
    if (!fired) begin
      $display("gpio interrupt %0d did not rise within %0d cycles", bit_on, POLL_TIMEOUT);
      errors++;
    end
    expect_eq("irq_o", irq, 32'(1) << (`MCU_IRQ_GPIO_BASE + bit_on));
    ao_read(AO_GPIO_INTR_STATUS, rdata);
    expect_eq("AO_GPIO_INTR_STATUS", rdata, 32'(1) << bit_on);
    // edge on a bit whose enable is clear
    gpio_in[bit_off] = 1'b1;
    idle_cycles(8);
    expect_eq("irq_o", irq, 32'(1) << (`MCU_IRQ_GPIO_BASE + bit_on));
    ao_read(AO_GPIO_INTR_STATUS, rdata);
    expect_eq("AO_GPIO_INTR_STATUS", rdata, 32'(1) << bit_on);
    ao_write(AO_GPIO_INTR_STATUS, 32'(1) << bit_on);
    expect_eq("irq_o", irq, 32'h0);
    ao_read(AO_GPIO_INTR_STATUS, rdata);
    expect_eq("AO_GPIO_INTR_STATUS", rdata, 32'h0);
    gpio_in = '0;
    finish_test("gpio_irq", start);
  endtask

  initial begin
    void'($urandom(33));
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    arst_n       = 1'b0;
    obi_req      = '0;
    gpio_in      = '0;
    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;
    reset_timing_test();
    ram_test();
    unmapped_test();
    exit_gpio_test();
    timer_test();
    gpio_irq_test();
    $display("tests run %0d, tests failing %0d, failed checks %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/ao_periph_regs.sv
// Always-on registers: exit, gpio, gpio interrupts and timer settings.
// Writes honour byte enables. Undefined offsets read 0 and ignore writes.
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cfg.svh"

module ao_periph_regs
  import mcu_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  mem_req_t               req_i,
  output logic [31:0]            rdata_o,
  input  logic [`MCU_GPIO_W-1:0] gpio_i,
  output logic [`MCU_GPIO_W-1:0] gpio_o,
  output logic [`MCU_GPIO_W-1:0] gpio_oe_o,
  output logic                   exit_valid_o,
  output logic [31:0]            exit_value_o,
  output timer_cfg_t             timer_cfg_o,
  output logic                   timer_load_o,
  output logic [31:0]            timer_load_value_o,
  input  logic [31:0]            mtime_i,
  output logic [`MCU_GPIO_W-1:0] gpio_intr_o
);

  logic [`MCU_LOCAL_AW+1:0] reg_off;
  logic                     wr;
  logic [31:0]              wmask;
  logic                     exit_valid_q;
  logic [31:0]              exit_value_q;
  logic [`MCU_GPIO_W-1:0]   gpio_out_q, gpio_oe_q;
  logic [`MCU_GPIO_W-1:0]   intr_en_q, intr_status_q, status_clr;
  logic [`MCU_GPIO_W-1:0]   sync1_q, sync2_q, prev_q, rise;
  timer_cfg_t               timer_cfg_q;
  logic [31:0]              rdata_d, rdata_q;

  function automatic logic [31:0] be_merge(input logic [31:0] old_v,
                                           input logic [31:0] new_v,
                                           input logic [31:0] mask);
    return (old_v & ~mask) | (new_v & mask);
  endfunction

  assign reg_off = {req_i.addr, 2'b00};
  assign wr      = req_i.en && req_i.we;
  assign wmask   = {{8{req_i.be[3]}}, {8{req_i.be[2]}}, {8{req_i.be[1]}}, {8{req_i.be[0]}}};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      gpio_out_q   <= '0;
      gpio_oe_q    <= '0;
      intr_en_q    <= '0;
      timer_cfg_q  <= '0;
    end else if (wr) begin
      case (reg_off)
        AO_EXIT_VALID:     if (req_i.be[0]) exit_valid_q <= req_i.wdata[0];
        AO_EXIT_VALUE:     exit_value_q <= be_merge(exit_value_q, req_i.wdata, wmask);
        AO_GPIO_OUT:       gpio_out_q <= `MCU_GPIO_W'(be_merge(32'(gpio_out_q), req_i.wdata, wmask));
        AO_GPIO_OE:        gpio_oe_q <= `MCU_GPIO_W'(be_merge(32'(gpio_oe_q), req_i.wdata, wmask));
        AO_TIMER_CTRL:     if (req_i.be[0]) timer_cfg_q.enable <= req_i.wdata[0];
        AO_TIMER_PRESCALE: begin
          timer_cfg_q.prescale <= 16'(be_merge(32'(timer_cfg_q.prescale), req_i.wdata, wmask));
        end
        AO_TIMER_CMP:      timer_cfg_q.cmp <= be_merge(timer_cfg_q.cmp, req_i.wdata, wmask);
        AO_GPIO_INTR_EN:   intr_en_q <= `MCU_GPIO_W'(be_merge(32'(intr_en_q), req_i.wdata, wmask));
        default: ;
      endcase
    end
  end

  // two-flop synchronizer, then a flop for rising-edge detect
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync1_q       <= '0;
      sync2_q       <= '0;
      prev_q        <= '0;
      intr_status_q <= '0;
    end else begin
      sync1_q       <= gpio_i;
      sync2_q       <= sync1_q;
      prev_q        <= sync2_q;
      // a new edge wins over a clear in the same cycle
      intr_status_q <= (intr_status_q & ~status_clr) | (rise & intr_en_q);
    end
  end

  assign rise       = sync2_q & ~prev_q;
  assign status_clr = (wr && reg_off == AO_GPIO_INTR_STATUS) ?
                      req_i.wdata[`MCU_GPIO_W-1:0] & wmask[`MCU_GPIO_W-1:0] : '0;

  always_comb begin
    rdata_d = '0;
    case (reg_off)
      AO_EXIT_VALID:       rdata_d[0] = exit_valid_q;
      AO_EXIT_VALUE:       rdata_d = exit_value_q;
      AO_GPIO_OUT:         rdata_d[`MCU_GPIO_W-1:0] = gpio_out_q;
      AO_GPIO_OE:          rdata_d[`MCU_GPIO_W-1:0] = gpio_oe_q;
      AO_GPIO_IN:          rdata_d[`MCU_GPIO_W-1:0] = sync2_q;
      AO_TIMER_CTRL:       rdata_d[0] = timer_cfg_q.enable;
      AO_TIMER_PRESCALE:   rdata_d[15:0] = timer_cfg_q.prescale;
      AO_TIMER_VALUE:      rdata_d = mtime_i;
      AO_TIMER_CMP:        rdata_d = timer_cfg_q.cmp;
      AO_GPIO_INTR_EN:     rdata_d[`MCU_GPIO_W-1:0] = intr_en_q;
      AO_GPIO_INTR_STATUS: rdata_d[`MCU_GPIO_W-1:0] = intr_status_q;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.en && !req_i.we) rdata_q <= rdata_d;
  end

  // load goes straight to the timer so it lands on the grant edge
  assign timer_load_o       = wr && (reg_off == AO_TIMER_VALUE);
  assign timer_load_value_o = req_i.wdata;

  assign rdata_o      = rdata_q;
  assign gpio_o       = gpio_out_q;
  assign gpio_oe_o    = gpio_oe_q;
  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;
  assign timer_cfg_o  = timer_cfg_q;
  assign gpio_intr_o  = intr_status_q & intr_en_q;

endmodule

`default_nettype wire

// File: source/mcu_cfg.svh
// Memory map, sizes and interrupt positions of the always-on slice.
// Bank count and words per bank must be powers of two. The RAM window must fit
// in MCU_LOCAL_AW word-address bits.

`ifndef MCU_CFG_SVH
`define MCU_CFG_SVH

// ram banks, contiguous from the RAM base
`define MCU_NUM_BANKS 2
`define MCU_BANK_WORDS 256

// address windows
`define MCU_RAM_BASE 32'h0000_0000
`define MCU_AO_BASE 32'h2000_0000
`define MCU_AO_SIZE 32'h0000_1000

// local word address handed to the slaves, covers the 4 KiB AO window
`define MCU_LOCAL_AW 10

// always-on gpio count
`define MCU_GPIO_W 8

// positions in the 32-bit interrupt vector
`define MCU_IRQ_TIMER_BIT 7
`define MCU_IRQ_GPIO_BASE 22

`endif

// File: source/mcu_pkg.sv
// Bus, timer and register types shared by the slice.
// Field widths follow the macros in the config header.
`default_nettype none

`include "mcu_cfg.svh"

package mcu_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_rsp_t;

  // single-cycle access to one slave, word addressed
  typedef struct packed {
    logic                     en;
    logic                     we;
    logic [3:0]               be;
    logic [`MCU_LOCAL_AW-1:0] addr;
    logic [31:0]              wdata;
  } mem_req_t;

  typedef struct packed {
    logic        enable;
    logic [15:0] prescale;
    logic [31:0] cmp;
  } timer_cfg_t;

  typedef enum logic {
    BUS_IDLE,
    BUS_RESP
  } bus_state_e;

  typedef enum logic [1:0] {
    TGT_RAM,
    TGT_AO,
    TGT_NONE
  } bus_target_e;

  // byte offsets inside the always-on window
  typedef enum logic [`MCU_LOCAL_AW+1:0] {
    AO_EXIT_VALID       = 'h00,
    AO_EXIT_VALUE       = 'h04,
    AO_GPIO_OUT         = 'h08,
    AO_GPIO_OE          = 'h0C,
    AO_GPIO_IN          = 'h10,
    AO_TIMER_CTRL       = 'h14,
    AO_TIMER_PRESCALE   = 'h18,
    AO_TIMER_VALUE      = 'h1C,
    AO_TIMER_CMP        = 'h20,
    AO_GPIO_INTR_EN     = 'h24,
    AO_GPIO_INTR_STATUS = 'h28
  } ao_reg_e;

endpackage

`default_nettype wire

// File: source/mini_mcu_top.sv
// Always-on MCU slice driven from a single OBI port.
// irq_o follows the usual layout: timer at bit 7, gpio in the fast field.
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cfg.svh"

module mini_mcu_top
  import mcu_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  obi_req_t               obi_req_i,
  output obi_rsp_t               obi_rsp_o,
  input  logic [`MCU_GPIO_W-1:0] gpio_i,
  output logic [`MCU_GPIO_W-1:0] gpio_o,
  output logic [`MCU_GPIO_W-1:0] gpio_oe_o,
  output logic                   exit_valid_o,
  output logic [31:0]            exit_value_o,
  output logic [31:0]            irq_o
);

  mem_req_t               ram_req;
  mem_req_t               ao_req;
  logic [31:0]            ram_rdata;
  logic [31:0]            ao_rdata;
  timer_cfg_t             timer_cfg;
  logic                   timer_load;
  logic [31:0]            timer_load_value;
  logic [31:0]            mtime;
  logic                   timer_intr;
  logic [`MCU_GPIO_W-1:0] gpio_intr;

  obi_bus_ctrl u_bus_ctrl (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .obi_req_i   (obi_req_i),
    .obi_rsp_o   (obi_rsp_o),
    .ram_req_o   (ram_req),
    .ao_req_o    (ao_req),
    .ram_rdata_i (ram_rdata),
    .ao_rdata_i  (ao_rdata)
  );

  ram_bank_array u_ram (
    .clk_i   (clk_i),
    .req_i   (ram_req),
    .rdata_o (ram_rdata)
  );

  ao_periph_regs u_ao_regs (
    .clk_i              (clk_i),
    .arst_n_i           (arst_n_i),
    .req_i              (ao_req),
    .rdata_o            (ao_rdata),
    .gpio_i             (gpio_i),
    .gpio_o             (gpio_o),
    .gpio_oe_o          (gpio_oe_o),
    .exit_valid_o       (exit_valid_o),
    .exit_value_o       (exit_value_o),
    .timer_cfg_o        (timer_cfg),
    .timer_load_o       (timer_load),
    .timer_load_value_o (timer_load_value),
    .mtime_i            (mtime),
    .gpio_intr_o        (gpio_intr)
  );

  rv_timer u_timer (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cfg_i        (timer_cfg),
    .load_i       (timer_load),
    .load_value_i (timer_load_value),
    .mtime_o      (mtime),
    .intr_o       (timer_intr)
  );

  // all other sources are gone, their bits stay zero
  always_comb begin
    irq_o                                       = '0;
    irq_o[`MCU_IRQ_TIMER_BIT]                   = timer_intr;
    irq_o[`MCU_IRQ_GPIO_BASE +: `MCU_GPIO_W]    = gpio_intr;
  end

endmodule

`default_nettype wire

// File: source/obi_bus_ctrl.sv
// OBI slave front end with one access in flight at a time.
// Unmapped addresses are granted and answered with err and zero data.
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cfg.svh"

module obi_bus_ctrl
  import mcu_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  obi_req_t    obi_req_i,
  output obi_rsp_t    obi_rsp_o,
  output mem_req_t    ram_req_o,
  output mem_req_t    ao_req_o,
  input  logic [31:0] ram_rdata_i,
  input  logic [31:0] ao_rdata_i
);

  localparam logic [31:0] RAM_BYTES = 32'(`MCU_NUM_BANKS * `MCU_BANK_WORDS * 4);

  bus_state_e               state_q, state_d;
  bus_target_e              tgt_d, tgt_q;
  logic                     gnt;
  logic [31:0]              ram_off;
  logic [31:0]              ao_off;
  logic [`MCU_LOCAL_AW-1:0] local_addr;

  // offsets wrap below the base, so one compare covers both ends
  assign ram_off = obi_req_i.addr - `MCU_RAM_BASE;
  assign ao_off  = obi_req_i.addr - `MCU_AO_BASE;

  always_comb begin
    tgt_d      = TGT_NONE;
    local_addr = '0;
    if (ram_off < RAM_BYTES) begin
      tgt_d      = TGT_RAM;
      local_addr = ram_off[`MCU_LOCAL_AW+1:2];
    end else if (ao_off < `MCU_AO_SIZE) begin
      tgt_d      = TGT_AO;
      local_addr = ao_off[`MCU_LOCAL_AW+1:2];
    end
  end

  // no grant while the response is out
  assign gnt = obi_req_i.req && (state_q == BUS_IDLE);

  always_comb begin
    ram_req_o.en    = gnt && (tgt_d == TGT_RAM);
    ram_req_o.we    = obi_req_i.we;
    ram_req_o.be    = obi_req_i.be;
    ram_req_o.addr  = local_addr;
    ram_req_o.wdata = obi_req_i.wdata;
    ao_req_o        = ram_req_o;
    ao_req_o.en     = gnt && (tgt_d == TGT_AO);
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      BUS_IDLE: if (gnt) state_d = BUS_RESP;
      BUS_RESP: state_d = BUS_IDLE;
      default:  state_d = BUS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= BUS_IDLE;
      tgt_q   <= TGT_NONE;
    end else begin
      state_q <= state_d;
      if (gnt) tgt_q <= tgt_d;
    end
  end

  // response one cycle after the grant
  always_comb begin
    obi_rsp_o.gnt    = gnt;
    obi_rsp_o.rvalid = (state_q == BUS_RESP);
    obi_rsp_o.err    = (state_q == BUS_RESP) && (tgt_q == TGT_NONE);
    case (tgt_q)
      TGT_RAM: obi_rsp_o.rdata = ram_rdata_i;
      TGT_AO:  obi_rsp_o.rdata = ao_rdata_i;
      default: obi_rsp_o.rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/ram_bank_array.sv
// Word RAM split into banks, byte-enable writes, read data one cycle later.
// Contents are not reset. Address bits above the banked range are ignored.
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cfg.svh"

module ram_bank_array
  import mcu_pkg::*;
(
  input  logic        clk_i,
  input  mem_req_t    req_i,
  output logic [31:0] rdata_o
);

  localparam int BANK_BITS = $clog2(`MCU_NUM_BANKS);
  localparam int WORD_BITS = $clog2(`MCU_BANK_WORDS);

  logic [BANK_BITS-1:0] bank_sel;
  logic [WORD_BITS-1:0] word_sel;
  logic [31:0]          bank_rword [`MCU_NUM_BANKS];
  logic [31:0]          rdata_q;

  // low bits pick the word, the bits above pick the bank
  assign word_sel = req_i.addr[WORD_BITS-1:0];
  assign bank_sel = req_i.addr[WORD_BITS +: BANK_BITS];

  for (genvar g = 0; g < `MCU_NUM_BANKS; g++) begin : g_bank
    logic [31:0] mem_q [`MCU_BANK_WORDS];
    logic        bank_we;

    assign bank_we = req_i.en && req_i.we && (bank_sel == BANK_BITS'(g));

    always_ff @(posedge clk_i) begin
      if (bank_we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.be[b]) begin
            mem_q[word_sel][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
    end

    assign bank_rword[g] = mem_q[word_sel];
  end

  // only reads update the output word
  always_ff @(posedge clk_i) begin
    if (req_i.en && !req_i.we) begin
      rdata_q <= bank_rword[bank_sel];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: source/rv_timer.sv
// 32-bit machine timer, one tick every prescale+1 enabled cycles.
// The interrupt is a level while enabled and mtime >= cmp. mtime wraps silently.
`timescale 1ns/1ps
`default_nettype none

`include "mcu_cfg.svh"

module rv_timer
  import mcu_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  timer_cfg_t  cfg_i,
  input  logic        load_i,
  input  logic [31:0] load_value_i,
  output logic [31:0] mtime_o,
  output logic        intr_o
);

  logic [15:0] presc_q;
  logic [31:0] mtime_q;
  logic        tick;

  // >= so a prescale lowered below the count still wraps
  assign tick = cfg_i.enable && (presc_q >= cfg_i.prescale);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      presc_q <= '0;
      mtime_q <= '0;
    end else if (load_i) begin
      // a load restarts the prescaler as well
      presc_q <= '0;
      mtime_q <= load_value_i;
    end else if (cfg_i.enable) begin
      if (tick) begin
        presc_q <= '0;
        mtime_q <= mtime_q + 32'd1;
      end else begin
        presc_q <= presc_q + 16'd1;
      end
    end
  end

  assign mtime_o = mtime_q;
  assign intr_o  = cfg_i.enable && (mtime_q >= cfg_i.cmp);

endmodule

`default_nettype wire
